// File: fpm_macros.svh
// width and constant macros included by the multiplier rtl and its testbench
`ifndef FPM_MACROS_SVH
`define FPM_MACROS_SVH

`define FPM_EXP_W 8
`define FPM_FRAC_W 23

// fraction plus the hidden one
`define FPM_SIG_W 24
`define FPM_PROD_W 48

`define FPM_BIAS 127
`define FPM_EXP_MAX 255

// radix-8 digits for a 24-bit unsigned multiplier with zero pad on both ends
`define FPM_BOOTH_DIGITS 9

// quiet nan, top fraction bit only
`define FPM_QNAN_FRAC 23'h400000

`endif

// File: fpm_pkg.sv
// float word, rounding mode and control state types imported by the multiplier rtl and testbench
`include "fpm_macros.svh"

package fpm_pkg;

  typedef struct packed {
    logic                   sign;
    logic [`FPM_EXP_W-1:0]  exp;
    logic [`FPM_FRAC_W-1:0] frac;
  } fp32_t;

  // codes 5..7 round like RMM
  typedef enum logic [2:0] {
    RNE = 3'd0,
    RTZ = 3'd1,
    RDN = 3'd2,
    RUP = 3'd3,
    RMM = 3'd4
  } round_mode_e;

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    MUL  = 2'd1,
    DONE = 2'd2
  } ctrl_state_e;

endpackage

// File: fpm_ctrl.sv
`timescale 1ns/1ps
// runs one multiply per four-phase req/ack handshake and holds the result while ack is high
module fpm_ctrl
  import fpm_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic        req,
  input  round_mode_e r_mode,
  input  fp32_t       fp_x,
  input  fp32_t       fp_y,
  input  logic        mul_done,
  input  fp32_t       res_word,
  input  logic        res_ovrf,
  input  logic        res_udrf,
  output logic        ack,
  output logic        load,
  output logic        step,
  output fp32_t       op_x,
  output fp32_t       op_y,
  output round_mode_e mode,
  output fp32_t       fp_z,
  output logic        ovrf,
  output logic        udrf
);

  ctrl_state_e state;
  logic        start;
  logic        finish;

  assign start  = (state == IDLE) && req;
  // done from the previous operation is still visible while load is high
  assign finish = (state == MUL) && !load && mul_done;
  assign step   = (state == MUL) && !load && !mul_done;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
      load  <= 1'b0;
      ack   <= 1'b0;
      fp_z  <= '0;
      ovrf  <= 1'b0;
      udrf  <= 1'b0;
    end else begin
      load <= start;  // one-cycle pulse into booth_mul
      case (state)
        IDLE: begin
          if (start) begin
            state <= MUL;
          end
        end
        MUL: begin
          if (finish) begin
            state <= DONE;
            ack   <= 1'b1;
            fp_z  <= res_word;
            ovrf  <= res_ovrf;
            udrf  <= res_udrf;
          end
        end
        DONE: begin
          if (!req) begin
            state <= IDLE;
            ack   <= 1'b0;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // operands held for the whole operation
  always_ff @(posedge clk) begin
    if (start) begin
      op_x <= fp_x;
      op_y <= fp_y;
      mode <= r_mode;
    end
  end

endmodule

// File: booth_mul.sv
`timescale 1ns/1ps
// iterative radix-8 booth multiplier for 24-bit significands, one digit per step pulse
`include "fpm_macros.svh"

module booth_mul (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   load,
  input  logic                   step,
  input  logic [`FPM_SIG_W-1:0]  sig_x,
  input  logic [`FPM_SIG_W-1:0]  sig_y,
  output logic [`FPM_PROD_W-1:0] product,
  output logic                   done
);

  localparam int PW    = `FPM_PROD_W;
  localparam int SR_W  = `FPM_SIG_W + 4;  // 3 zero bits above, pad bit below
  localparam int CNT_W = $clog2(`FPM_BOOTH_DIGITS + 1);
  localparam logic [CNT_W-1:0] LAST = CNT_W'(`FPM_BOOTH_DIGITS - 1);

  logic [SR_W-1:0]      mult_sr;
  logic [PW-1:0]        x1_sh;    // multiplicand at the current digit weight
  logic [PW-1:0]        x3_sh;
  logic signed [PW-1:0] acc;      // wraps mod 2^48, final sum is exact
  logic [PW-1:0]        multiple;
  logic                 neg;
  logic [CNT_W-1:0]     cnt;

  // digit = -4*b3 + 2*b2 + b1 + b0
  always_comb begin
    neg = mult_sr[3];
    case (mult_sr[3:0])
      4'b0000, 4'b1111:                   multiple = '0;
      4'b0001, 4'b0010, 4'b1101, 4'b1110: multiple = x1_sh;
      4'b0011, 4'b0100, 4'b1011, 4'b1100: multiple = x1_sh << 1;
      4'b0101, 4'b0110, 4'b1001, 4'b1010: multiple = x3_sh;
      default:                            multiple = x1_sh << 2;  // +4 or -4
    endcase
  end

  always_ff @(posedge clk) begin
    if (load) begin
      x1_sh   <= PW'(sig_x);
      x3_sh   <= PW'(sig_x) + (PW'(sig_x) << 1);
      acc     <= '0;
      mult_sr <= {3'b000, sig_y, 1'b0};
    end else if (step) begin
      acc     <= neg ? acc - multiple : acc + multiple;
      x1_sh   <= x1_sh << 3;
      x3_sh   <= x3_sh << 3;
      mult_sr <= mult_sr >> 3;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt  <= '0;
      done <= 1'b0;
    end else if (load) begin
      cnt  <= '0;
      done <= 1'b0;
    end else if (step) begin
      cnt <= cnt + 1'b1;
      if (cnt == LAST) begin
        done <= 1'b1;
      end
    end
  end

  assign product = acc;

endmodule

// File: fp_round.sv
`timescale 1ns/1ps
// normalizes the raw significand product by one place and rounds it to a 23-bit fraction
`include "fpm_macros.svh"

module fp_round
  import fpm_pkg::*;
(
  input  logic [`FPM_PROD_W-1:0] product,
  input  logic                   sign,
  input  round_mode_e            mode,
  output logic [`FPM_FRAC_W-1:0] frac,
  output logic                   norm
);

  localparam int PW = `FPM_PROD_W;
  localparam int SW = `FPM_SIG_W;
  localparam int FW = `FPM_FRAC_W;
  localparam int G_BIT = PW - SW - 1;

  logic [PW-1:0] shifted;
  logic [SW-1:0] sig;
  logic          guard;
  logic          rnd;
  logic          sticky;
  logic          inexact;
  logic          round_up;
  logic [SW:0]   rounded;  // extra bit catches the carry out

  // product is in [1,4), so one left shift at most
  assign shifted = product[PW-1] ? product : product << 1;

  assign sig     = shifted[PW-1 -: SW];
  assign guard   = shifted[G_BIT];
  assign rnd     = shifted[G_BIT-1];
  assign sticky  = |shifted[G_BIT-2:0];
  assign inexact = guard | rnd | sticky;

  always_comb begin
    case (mode)
      RNE:     round_up = guard & (rnd | sticky | sig[0]);  // ties to even
      RTZ:     round_up = 1'b0;
      RDN:     round_up = sign & inexact;
      RUP:     round_up = !sign & inexact;
      default: round_up = guard;  // RMM and the unused codes
    endcase
  end

  assign rounded = {1'b0, sig} + {{SW{1'b0}}, round_up};

  // all-ones significand rounding up becomes 10.0, renormalize
  assign norm = product[PW-1] | rounded[SW];
  assign frac = rounded[SW] ? rounded[SW-1:1] : rounded[FW-1:0];

endmodule

// File: fp_result.sv
`timescale 1ns/1ps
// exponent sum with overflow and underflow, special value handling and final word assembly
`include "fpm_macros.svh"

module fp_result
  import fpm_pkg::*;
(
  input  fp32_t                  op_x,
  input  fp32_t                  op_y,
  input  logic [`FPM_FRAC_W-1:0] frac,
  input  logic                   norm,
  output fp32_t                  res_word,
  output logic                   res_ovrf,
  output logic                   res_udrf
);

  localparam int EW    = `FPM_EXP_W;
  localparam int SUM_W = EW + 2;  // room for 255 plus bias
  localparam logic [EW-1:0] BIAS    = EW'(`FPM_BIAS);
  localparam logic [EW-1:0] EXP_MAX = EW'(`FPM_EXP_MAX);

  logic [SUM_W-1:0] exp_sum;
  logic [EW-1:0]    bias;
  logic [EW-1:0]    exp_z;
  logic             sign;
  logic             zer_x;
  logic             zer_y;
  logic             inf_x;
  logic             inf_y;
  logic             nan_x;
  logic             nan_y;
  logic             is_nan;
  logic             is_inf;
  logic             is_zer;

  assign sign    = op_x.sign ^ op_y.sign;
  assign bias    = BIAS - {{(EW-1){1'b0}}, norm};  // 126 when the product was >= 2
  assign exp_sum = SUM_W'(op_x.exp) + SUM_W'(op_y.exp);
  assign exp_z   = op_x.exp + op_y.exp - bias;

  assign res_ovrf = exp_sum >= SUM_W'(EXP_MAX) + SUM_W'(bias);
  assign res_udrf = exp_sum <= SUM_W'(bias);

  // exponent 0 counts as zero, subnormals flushed
  assign zer_x = op_x.exp == '0;
  assign zer_y = op_y.exp == '0;
  assign inf_x = (op_x.exp == EXP_MAX) && (op_x.frac == '0);
  assign inf_y = (op_y.exp == EXP_MAX) && (op_y.frac == '0);
  assign nan_x = (op_x.exp == EXP_MAX) && (op_x.frac != '0);
  assign nan_y = (op_y.exp == EXP_MAX) && (op_y.frac != '0);

  assign is_nan = nan_x | nan_y | (inf_x & zer_y) | (inf_y & zer_x);
  assign is_inf = inf_x | inf_y | res_ovrf;
  assign is_zer = zer_x | zer_y | res_udrf;

  always_comb begin
    res_word.sign = sign;
    if (is_nan) begin
      res_word.exp  = EXP_MAX;
      res_word.frac = `FPM_QNAN_FRAC;
    end else if (is_inf) begin
      res_word.exp  = EXP_MAX;
      res_word.frac = '0;
    end else if (is_zer) begin
      res_word.exp  = '0;
      res_word.frac = '0;
    end else begin
      res_word.exp  = exp_z;
      res_word.frac = frac;
    end
  end

endmodule

// File: fpm_top.sv
`timescale 1ns/1ps
// clocked single-precision multiplier top level behind a four-phase req/ack handshake
`include "fpm_macros.svh"

module fpm_top
  import fpm_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic        req,
  input  round_mode_e r_mode,
  input  fp32_t       fp_x,
  input  fp32_t       fp_y,
  output logic        ack,
  output fp32_t       fp_z,
  output logic        ovrf,
  output logic        udrf
);

  logic                   load;
  logic                   step;
  logic                   mul_done;
  fp32_t                  op_x;
  fp32_t                  op_y;
  fp32_t                  res_word;
  round_mode_e            mode;
  logic [`FPM_SIG_W-1:0]  sig_x;
  logic [`FPM_SIG_W-1:0]  sig_y;
  logic [`FPM_PROD_W-1:0] product;
  logic [`FPM_FRAC_W-1:0] frac;
  logic                   norm;
  logic                   sign_z;
  logic                   res_ovrf;
  logic                   res_udrf;

  // hidden one always set, zero exponents are caught in fp_result
  assign sig_x  = {1'b1, op_x.frac};
  assign sig_y  = {1'b1, op_y.frac};
  assign sign_z = op_x.sign ^ op_y.sign;

  fpm_ctrl fpm_ctrl (
    .clk      (clk),
    .arst_n   (arst_n),
    .req      (req),
    .r_mode   (r_mode),
    .fp_x     (fp_x),
    .fp_y     (fp_y),
    .mul_done (mul_done),
    .res_word (res_word),
    .res_ovrf (res_ovrf),
    .res_udrf (res_udrf),
    .ack      (ack),
    .load     (load),
    .step     (step),
    .op_x     (op_x),
    .op_y     (op_y),
    .mode     (mode),
    .fp_z     (fp_z),
    .ovrf     (ovrf),
    .udrf     (udrf)
  );

  booth_mul booth_mul (
    .clk     (clk),
    .arst_n  (arst_n),
    .load    (load),
    .step    (step),
    .sig_x   (sig_x),
    .sig_y   (sig_y),
    .product (product),
    .done    (mul_done)
  );

  fp_round fp_round (
    .product (product),
    .sign    (sign_z),
    .mode    (mode),
    .frac    (frac),
    .norm    (norm)
  );

  fp_result fp_result (
    .op_x     (op_x),
    .op_y     (op_y),
    .frac     (frac),
    .norm     (norm),
    .res_word (res_word),
    .res_ovrf (res_ovrf),
    .res_udrf (res_udrf)
  );

endmodule

// File: fpm_properties.sv
`timescale 1ns/1ps
// handshake and flag assertions, bound into the multiplier top level for simulation
module fpm_properties
  import fpm_pkg::*;
(
  input logic  clk,
  input logic  arst_n,
  input logic  req,
  input logic  ack,
  input fp32_t fp_z,
  input logic  ovrf,
  input logic  udrf
);

  // requester holds req until it sees ack
  ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(ack) |-> req)
    else $error("ack rose while req was low");

  ack_falls_after_req: assert property (@(posedge clk) disable iff (!arst_n)
    $fell(ack) |-> !$past(req))
    else $error("ack fell while req was still high");

  result_held: assert property (@(posedge clk) disable iff (!arst_n)
    (ack && $past(ack)) |-> ($stable(fp_z) && $stable(ovrf) && $stable(udrf)))
    else $error("result changed while ack was high");

  flags_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
    !(ovrf && udrf))
    else $error("overflow and underflow raised together");

endmodule

bind fpm_top fpm_properties props (
  .clk    (clk),
  .arst_n (arst_n),
  .req    (req),
  .ack    (ack),
  .fp_z   (fp_z),
  .ovrf   (ovrf),
  .udrf   (udrf)
);

// File: fpm_tb.sv
`timescale 1ns/1ps
// directed tests for the float multiplier against a behavioral model, run with the Makefile
`include "fpm_macros.svh"

module fpm_tb
  import fpm_pkg::*;
();

  localparam int N_TXN       = 106;  // transactions issued by all tests together
  localparam int CYCLE_LIMIT = 60 * N_TXN;
  localparam int LATENCY     = 11;

  logic        clk = 1'b0;
  logic        arst_n;
  logic        req;
  round_mode_e r_mode;
  fp32_t       fp_x;
  fp32_t       fp_y;
  logic        ack;
  fp32_t       fp_z;
  logic        ovrf;
  logic        udrf;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  logic [31:0] rng = 32'h502e431b;

  fpm_top UUT (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (req),
    .r_mode (r_mode),
    .fp_x   (fp_x),
    .fp_y   (fp_y),
    .ack    (ack),
    .fp_z   (fp_z),
    .ovrf   (ovrf),
    .udrf   (udrf)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the DUT stopped answering", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  // normal operand, exponent 64..189 keeps the product clear of both flags
  function automatic logic [31:0] random_normal();
    logic [7:0] e;
    rng = xorshift32(rng);
    e   = 8'd64 + rng[15:8] % 8'd126;
    rng = xorshift32(rng);
    return {rng[31], e, rng[22:0]};
  endfunction

  // returns {udrf, ovrf, word}
  function automatic logic [33:0] model_mul(input logic [31:0] a, input logic [31:0] b,
                                            input logic [2:0] rm);
    logic [63:0] p;
    logic [63:0] keep;
    logic [63:0] rem;
    logic [63:0] half;
    logic [31:0] z;
    logic [1:0]  zero;
    logic [1:0]  inf;
    logic [1:0]  nan;
    logic        sign;
    logic        up;
    logic        norm;
    logic        ov;
    logic        ud;
    int          sh;
    int          esum;
    int          bias;
    sign = a[31] ^ b[31];
    p    = {40'd0, 1'b1, a[22:0]} * {40'd0, 1'b1, b[22:0]};
    sh   = p[47] ? 24 : 23;  // bits below the kept 24-bit significand
    keep = p >> sh;
    rem  = p & ((64'd1 << sh) - 64'd1);
    half = 64'd1 << (sh - 1);
    case (rm)
      RNE:     up = (rem > half) || (rem == half && keep[0]);
      RTZ:     up = 1'b0;
      RDN:     up = sign && rem != 64'd0;
      RUP:     up = !sign && rem != 64'd0;
      default: up = rem >= half;
    endcase
    keep = keep + 64'(up);
    norm = p[47] || keep[24];
    if (keep[24]) begin
      keep = keep >> 1;
    end
    bias = `FPM_BIAS - int'(norm);
    esum = int'(a[30:23]) + int'(b[30:23]);
    ov   = esum >= `FPM_EXP_MAX + bias;
    ud   = esum <= bias;
    zero = {b[30:23] == 8'd0, a[30:23] == 8'd0};
    inf  = {b[30:23] == 8'hFF && b[22:0] == 23'd0, a[30:23] == 8'hFF && a[22:0] == 23'd0};
    nan  = {b[30:23] == 8'hFF && b[22:0] != 23'd0, a[30:23] == 8'hFF && a[22:0] != 23'd0};
    if (|nan || (inf[0] && zero[1]) || (inf[1] && zero[0])) begin
      z = {sign, 8'hFF, `FPM_QNAN_FRAC};
    end else if (|inf || ov) begin
      z = {sign, 8'hFF, 23'd0};
    end else if (|zero || ud) begin
      z = {sign, 31'd0};
    end else begin
      z = {sign, 8'(esum - bias), keep[22:0]};
    end
    return {ud, ov, z};
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] expv);
    checks++;
    assert (got === expv) else begin
      errors++;
      $display("MISMATCH %s: got %h expected %h", name, got, expv);
    end
  endtask

  // one full four-phase transaction, req held for hold extra cycles after ack
  task automatic run_op(input logic [31:0] x, input logic [31:0] y, input logic [2:0] rm,
                        input int hold);
    logic [33:0] expv;
    logic [31:0] held;
    int          edges;
    expv = model_mul(x, y, rm);
    @(posedge clk);
    req    <= 1'b1;
    r_mode <= round_mode_e'(rm);
    fp_x   <= x;
    fp_y   <= y;
    @(posedge clk);  // DUT samples req here
    edges = 0;
    do begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end while (!ack);
    checks++;
    assert (edges == LATENCY) else begin
      errors++;
      $display("ack came %0d edges after req was sampled instead of %0d", edges, LATENCY);
    end
    compare_value("fp_z", fp_z, expv[31:0]);
    compare_value("ovrf", 32'(ovrf), 32'(expv[32]));
    compare_value("udrf", 32'(udrf), 32'(expv[33]));
    held = fp_z;
    repeat (hold) begin
      @(posedge clk);
      @(negedge clk);
      checks++;
      assert (ack && fp_z === held) else begin
        errors++;
        $display("ack or result changed while req was still high");
      end
    end
    @(posedge clk);
    req <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    checks++;
    assert (!ack) else begin
      errors++;
      $display("ack stayed high after req dropped");
    end
  endtask

  task automatic handshake_timing();
    checks++;
    assert (!ack && fp_z === '0 && !ovrf && !udrf) else begin
      errors++;
      $display("outputs not cleared by reset");
    end
    run_op(32'h3FC00000, 32'h40000000, RNE, 20);
  endtask

  // 1.0 times pi and -123.456, then 1.5 x 2.0 and -3.0 x 0.5
  task automatic exact_products();
    logic [31:0] xs [4] = '{32'h3F800000, 32'h3F800000, 32'h3FC00000, 32'hC0400000};
    logic [31:0] ys [4] = '{32'h40490FDB, 32'hC2F6E979, 32'h40000000, 32'h3F000000};
    for (int i = 0; i < 4; i++) begin
      for (int m = 0; m < 5; m++) begin
        run_op(xs[i], ys[i], 3'(m), 0);
      end
    end
  endtask

  task automatic random_normals();
    logic [31:0] x;
    logic [31:0] y;
    repeat (16) begin
      x = random_normal();
      y = random_normal();
      run_op(x, y, RNE, 0);
      run_op(x, y, RTZ, 0);
    end
  endtask

  // x times 1.5 leaves a tie, a below-half and an above-half remainder;
  // the last pair multiplies to 2^47-1, rounds to 2.0 and bumps the exponent
  task automatic rounding_modes();
    logic [31:0] xs [4] = '{32'h3FC00002, 32'h3FC00003, 32'h3FC00001, 32'h3FA1E58F};
    logic [31:0] ys [4] = '{32'h3FC00000, 32'h3FC00000, 32'h3FC00000, 32'h3FCA6691};
    for (int i = 0; i < 4; i++) begin
      for (int s = 0; s < 2; s++) begin
        for (int m = 0; m < 5; m++) begin
          run_op(xs[i] ^ ((s == 1) ? 32'h80000000 : 32'd0), ys[i], 3'(m), 0);
        end
      end
    end
  endtask

  // nan, -nan, inf, -inf, zero, -zero, inf x 0, subnormal
  task automatic special_values();
    logic [31:0] xs [8] = '{32'h7F800001, 32'h40000000, 32'h7F800000, 32'hFF800000,
                            32'h00000000, 32'h80000000, 32'h7F800000, 32'h00400000};
    logic [31:0] ys [8] = '{32'h3F800000, 32'hFFC00000, 32'h40000000, 32'h40400000,
                            32'h40A00000, 32'h3FC00000, 32'h00000000, 32'h40000000};
    for (int i = 0; i < 8; i++) begin
      run_op(xs[i], ys[i], RNE, 0);
    end
  endtask

  // two overflows, two underflows (one on the boundary), one mid-range
  task automatic overflow_underflow();
    logic [31:0] xs [5] = '{32'h7F000000, 32'hE0000000, 32'h0A000000, 32'h20000000,
                            32'h3F800000};
    logic [31:0] ys [5] = '{32'h7F000000, 32'h60000000, 32'h14000000, 32'h1F800000,
                            32'h40000000};
    for (int i = 0; i < 5; i++) begin
      run_op(xs[i], ys[i], RNE, 0);
    end
  endtask

  initial begin
    arst_n = 1'b0;
    req    = 1'b0;
    r_mode = RNE;
    fp_x   = '0;
    fp_y   = '0;
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    handshake_timing();
    exact_products();
    random_normals();
    rounding_modes();
    special_values();
    overflow_underflow();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+.
fpm_pkg.sv
fpm_ctrl.sv
booth_mul.sv
fp_round.sv
fp_result.sv
fpm_top.sv
fpm_properties.sv
fpm_tb.sv

// File: Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing --assert --timescale 1ns/1ps
SIM_FLAGS  ?= --binary --timing --assert --timescale 1ns/1ps
TOP        ?= fpm_tb
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   := TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
